// ==== Makefile ====
# Verilator flow for the dual channel load/store subsystem.
TOP = lsu_subsys_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+source
source/lsu_op_pkg.sv
source/mem_bus_pkg.sv
source/lsu_align.sv
source/lsu_channel.sv
source/mem_arbiter.sv
source/data_ram.sv
source/lsu_subsys.sv
verification/lsu_subsys_tb.sv

// ==== source/data_ram.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module data_ram (
   input  logic                      i_clk,
   input  logic                      i_rst_n,
   input  logic                      i_en,
   input  logic [`LSU_ADDR_W-3:0]    i_addr,
   input  logic                      i_we,
   input  mem_bus_pkg::mem_sel_t     i_sel,
   input  mem_bus_pkg::mem_word_u    i_wdata,
   output logic                      o_ack,
   output mem_bus_pkg::mem_word_u    o_rdata
);
   import mem_bus_pkg::*;

   mem_word_u mem_q [`LSU_RAM_DEPTH];
   mem_word_u rdata_q;
   logic      ack_q;

   always_ff @(posedge i_clk) begin
      if (i_en) begin
         for (int b = 0; b < MEM_LANES; b++) begin
            if (i_we && i_sel[b]) begin
               mem_q[i_addr].bytes[b] <= i_wdata.bytes[b]; // selected lanes only.
            end
         end
         rdata_q <= mem_q[i_addr]; // old word on a write.
      end
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_en; // answer one clock after the enable.
      end
   end

   assign o_ack   = ack_q;
   assign o_rdata = rdata_q;

endmodule

// ==== source/lsu_align.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_align (
   input  logic                                    i_clk,
   input  logic                                    i_rst_n,
   input  logic [lsu_op_pkg::LSU_BYTE_IDX_W-1:0]   i_bytecnt,
   input  logic [lsu_op_pkg::LSU_BYTE_IDX_W-1:0]   i_lsb,
   input  lsu_op_pkg::mem_size_e                   i_size,
   input  logic                                    i_signed,
   input  logic [`LSU_SERIAL_W-1:0]                i_dat,
   output logic [`LSU_SERIAL_W-1:0]                o_dat,
   output logic                                    o_byte_valid,
   output logic                                    o_misalign,
   output mem_bus_pkg::mem_sel_t                   o_sel
);
   import lsu_op_pkg::*;

   localparam int W = `LSU_SERIAL_W;

   logic                      is_word;
   logic                      is_half;
   logic                      dat_valid;   // serial chunk lies inside the access.
   logic                      sign_q;      // last sign bit seen.
   logic [LSU_BYTE_IDX_W:0]   lane_end;    // lane offset plus byte count.

   assign is_word = (i_size == MEM_WORD);
   assign is_half = (i_size == MEM_HALF);

   // a byte still fits in the word while offset plus count stays below 4.
   assign lane_end     = {1'b0, i_lsb} + {1'b0, i_bytecnt};
   assign o_byte_valid = ~lane_end[LSU_BYTE_IDX_W];

   // byte passes count 0, half passes counts 0 and 1, word passes all.
   assign dat_valid = is_word | (i_bytecnt == '0) | (is_half & ~i_bytecnt[1]);

   // past the access size the stream is filled with sign or zeros.
   assign o_dat = dat_valid ? i_dat : {W{i_signed & sign_q}};

   assign o_sel[3] = (i_lsb == 2'b11) | is_word | (is_half & i_lsb[1]);
   assign o_sel[2] = (i_lsb == 2'b10) | is_word;
   assign o_sel[1] = (i_lsb == 2'b01) | is_word | (is_half & ~i_lsb[1]);
   assign o_sel[0] = (i_lsb == 2'b00); // byte, half or word at offset 0.

   // odd half, or word off a 4-byte boundary.
   assign o_misalign = (i_lsb[0] & (is_word | is_half)) | (i_lsb[1] & is_word);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sign_q <= 1'b0;
      end else if (dat_valid) begin
         sign_q <= i_dat[W-1]; // top bit of the newest valid chunk.
      end
   end

endmodule

// ==== source/lsu_channel.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_channel (
   input  logic                                 i_clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_cmd_strobe,
   input  logic [`LSU_ADDR_W-1:0]               i_addr,
   input  lsu_op_pkg::mem_size_e                i_size,
   input  logic                                 i_signed,
   input  logic                                 i_store,
   input  logic [lsu_op_pkg::LSU_DATA_W-1:0]    i_wdata,
   output logic                                 o_busy,
   output logic                                 o_done,
   output logic                                 o_misalign,
   output logic [lsu_op_pkg::LSU_DATA_W-1:0]    o_rdata,
   output logic                                 o_bus_req,
   output logic [`LSU_ADDR_W-3:0]               o_bus_addr,
   output logic                                 o_bus_we,
   output mem_bus_pkg::mem_sel_t                o_bus_sel,
   output mem_bus_pkg::mem_word_u               o_bus_wdata,
   input  logic                                 i_bus_ack,
   input  mem_bus_pkg::mem_word_u               i_bus_rdata
);
   import lsu_op_pkg::*;

   localparam int W = `LSU_SERIAL_W;
   localparam logic [LSU_BITCNT_W-1:0] STEP = LSU_BITCNT_W'(W);
   localparam logic [LSU_BITCNT_W-1:0] LAST = LSU_BITCNT_W'(LSU_DATA_W - W);

   localparam logic [1:0] ST_IDLE    = 2'd0;
   localparam logic [1:0] ST_SHIFT   = 2'd1; // store lane alignment.
   localparam logic [1:0] ST_BUS     = 2'd2; // waiting for the ram.
   localparam logic [1:0] ST_UNSHIFT = 2'd3; // load extraction and extension.

   logic [1:0]                  state_q;
   logic [LSU_BITCNT_W-1:0]     bitcnt_q;
   logic                        done_q;
   logic                        misalign_q;
   logic [`LSU_ADDR_W-1:0]      addr_q;
   mem_size_e                   size_q;
   logic                        signed_q;
   logic                        store_q;
   logic [LSU_DATA_W-1:0]       buf_q;      // serial shift buffer.
   logic [LSU_DATA_W-1:0]       buf_rot;
   logic [LSU_DATA_W-1:0]       rdata_q;
   logic                        idle;
   logic                        accept;
   logic                        last_beat;
   logic [LSU_BYTE_IDX_W-1:0]   cur_lsb;
   mem_size_e                   cur_size;
   logic [W-1:0]                ser_in;
   logic [W-1:0]                algn_dat;
   logic                        algn_byte_valid;
   logic                        algn_misalign;

   assign idle      = (state_q == ST_IDLE);
   assign accept    = idle & i_cmd_strobe;
   assign last_beat = (bitcnt_q == LAST);

   // while idle the aligner checks the incoming command.
   assign cur_lsb  = idle ? i_addr[LSU_BYTE_IDX_W-1:0] : addr_q[LSU_BYTE_IDX_W-1:0];
   assign cur_size = idle ? i_size : size_q;

   assign buf_rot = {buf_q[W-1:0], buf_q[LSU_DATA_W-1:W]}; // rotate right by w.
   assign ser_in  = buf_q[{addr_q[LSU_BYTE_IDX_W-1:0], 3'b000} +: W]; // lane picked by offset.

   lsu_align i_lsu_align (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_bytecnt    (bitcnt_q[LSU_BITCNT_W-1 -: LSU_BYTE_IDX_W]),
      .i_lsb        (cur_lsb),
      .i_size       (cur_size),
      .i_signed     (signed_q),
      .i_dat        (ser_in),
      .o_dat        (algn_dat),
      .o_byte_valid (algn_byte_valid),
      .o_misalign   (algn_misalign),
      .o_sel        (o_bus_sel)
   );

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q    <= ST_IDLE;
         bitcnt_q   <= '0;
         done_q     <= 1'b0;
         misalign_q <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (i_cmd_strobe) begin
                  misalign_q <= algn_misalign;
                  bitcnt_q   <= '0;
                  if (algn_misalign) begin
                     done_q <= 1'b1;       // trap, no bus access.
                  end else if (i_store) begin
                     state_q <= ST_SHIFT;
                  end else begin
                     state_q <= ST_BUS;
                  end
               end
            end
            ST_SHIFT: begin
               bitcnt_q <= bitcnt_q + STEP; // wraps to 0 after the last beat.
               if (last_beat) state_q <= ST_BUS;
            end
            ST_BUS: begin
               if (i_bus_ack) begin
                  state_q <= store_q ? ST_IDLE : ST_UNSHIFT;
                  done_q  <= store_q;
               end
            end
            default: begin
               bitcnt_q <= bitcnt_q + STEP;
               if (last_beat) begin
                  state_q <= ST_IDLE;
                  done_q  <= 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept) begin
         addr_q   <= i_addr;
         size_q   <= i_size;
         signed_q <= i_signed;
         store_q  <= i_store;
         buf_q    <= i_wdata;
      end else if (state_q == ST_SHIFT && algn_byte_valid) begin
         buf_q <= buf_rot;                   // rotate only while the byte fits.
      end else if (state_q == ST_BUS && i_bus_ack && !store_q) begin
         buf_q <= i_bus_rdata.word;
      end else if (state_q == ST_UNSHIFT) begin
         buf_q <= buf_rot;
      end
      if (state_q == ST_UNSHIFT) begin
         rdata_q <= {algn_dat, rdata_q[LSU_DATA_W-1:W]}; // result fills from the top.
      end
   end

   assign o_busy           = ~idle;
   assign o_done           = done_q;
   assign o_misalign       = misalign_q;
   assign o_rdata          = rdata_q;
   assign o_bus_req        = (state_q == ST_BUS);
   assign o_bus_addr       = addr_q[`LSU_ADDR_W-1:LSU_BYTE_IDX_W];
   assign o_bus_we         = store_q;
   assign o_bus_wdata.word = buf_q;

endmodule

// ==== source/lsu_op_pkg.sv ====
package lsu_op_pkg;

   // access size of a load or store.
   typedef enum logic [1:0] {
      MEM_BYTE = 2'b00, // one byte.
      MEM_HALF = 2'b01, // two bytes, even address.
      MEM_WORD = 2'b10  // four bytes, word aligned.
   } mem_size_e;

   // store data and load result width.
   localparam int LSU_DATA_W = 32;

   // width of a byte index inside a word (lane offset, byte count).
   localparam int LSU_BYTE_IDX_W = 2;

   // width of the bit counter that walks one word.
   localparam int LSU_BITCNT_W = $clog2(LSU_DATA_W);

endpackage

// ==== source/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// bits moved per clock by the serial buffer, one of 1, 2 or 4.
`define LSU_SERIAL_W 1

// data ram depth in 32-bit words.
`define LSU_RAM_DEPTH 64

// byte address width, word index plus the two lane bits.
`define LSU_ADDR_W ($clog2(`LSU_RAM_DEPTH) + 2)

`endif

// ==== source/lsu_subsys.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_subsys (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_cmd_strobe_0,
   input  logic [`LSU_ADDR_W-1:0] i_addr_0,
   input  lsu_op_pkg::mem_size_e i_size_0,
   input  logic                  i_signed_0,
   input  logic                  i_store_0,
   input  logic [31:0]           i_wdata_0,
   output logic                  o_done_0,
   output logic [31:0]           o_rdata_0,
   output logic                  o_misalign_0,
   output logic                  o_busy_0,
   input  logic                  i_cmd_strobe_1,
   input  logic [`LSU_ADDR_W-1:0] i_addr_1,
   input  lsu_op_pkg::mem_size_e i_size_1,
   input  logic                  i_signed_1,
   input  logic                  i_store_1,
   input  logic [31:0]           i_wdata_1,
   output logic                  o_done_1,
   output logic [31:0]           o_rdata_1,
   output logic                  o_misalign_1,
   output logic                  o_busy_1
);
   import mem_bus_pkg::*;

   logic                   ch0_req, ch0_we, ch0_ack;
   logic                   ch1_req, ch1_we, ch1_ack;
   logic [`LSU_ADDR_W-3:0] ch0_addr, ch1_addr;
   mem_sel_t               ch0_sel, ch1_sel;
   mem_word_u              ch0_wdata, ch0_rdata, ch1_wdata, ch1_rdata;
   logic                   ram_en, ram_we, ram_ack;
   logic [`LSU_ADDR_W-3:0] ram_addr;
   mem_sel_t               ram_sel;
   mem_word_u              ram_wdata, ram_rdata;

   lsu_channel i_channel_0 (
      .i_clk (i_clk), .i_rst_n (i_rst_n),
      .i_cmd_strobe (i_cmd_strobe_0), .i_addr (i_addr_0), .i_size (i_size_0),
      .i_signed (i_signed_0), .i_store (i_store_0), .i_wdata (i_wdata_0),
      .o_busy (o_busy_0), .o_done (o_done_0), .o_misalign (o_misalign_0),
      .o_rdata (o_rdata_0), .o_bus_req (ch0_req), .o_bus_addr (ch0_addr),
      .o_bus_we (ch0_we), .o_bus_sel (ch0_sel), .o_bus_wdata (ch0_wdata),
      .i_bus_ack (ch0_ack), .i_bus_rdata (ch0_rdata)
   );

   lsu_channel i_channel_1 (
      .i_clk (i_clk), .i_rst_n (i_rst_n),
      .i_cmd_strobe (i_cmd_strobe_1), .i_addr (i_addr_1), .i_size (i_size_1),
      .i_signed (i_signed_1), .i_store (i_store_1), .i_wdata (i_wdata_1),
      .o_busy (o_busy_1), .o_done (o_done_1), .o_misalign (o_misalign_1),
      .o_rdata (o_rdata_1), .o_bus_req (ch1_req), .o_bus_addr (ch1_addr),
      .o_bus_we (ch1_we), .o_bus_sel (ch1_sel), .o_bus_wdata (ch1_wdata),
      .i_bus_ack (ch1_ack), .i_bus_rdata (ch1_rdata)
   );

   mem_arbiter i_mem_arbiter (
      .i_clk (i_clk), .i_rst_n (i_rst_n),
      .i_req_0 (ch0_req), .i_addr_0 (ch0_addr), .i_we_0 (ch0_we),
      .i_sel_0 (ch0_sel), .i_wdata_0 (ch0_wdata), .o_ack_0 (ch0_ack), .o_rdata_0 (ch0_rdata),
      .i_req_1 (ch1_req), .i_addr_1 (ch1_addr), .i_we_1 (ch1_we),
      .i_sel_1 (ch1_sel), .i_wdata_1 (ch1_wdata), .o_ack_1 (ch1_ack), .o_rdata_1 (ch1_rdata),
      .o_en (ram_en), .o_addr (ram_addr), .o_we (ram_we), .o_sel (ram_sel),
      .o_wdata (ram_wdata), .i_ack (ram_ack), .i_rdata (ram_rdata)
   );

   data_ram i_data_ram (
      .i_clk (i_clk), .i_rst_n (i_rst_n),
      .i_en (ram_en), .i_addr (ram_addr), .i_we (ram_we), .i_sel (ram_sel),
      .i_wdata (ram_wdata), .o_ack (ram_ack), .o_rdata (ram_rdata)
   );

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module mem_arbiter (
   input  logic                      i_clk,
   input  logic                      i_rst_n,
   input  logic                      i_req_0,
   input  logic [`LSU_ADDR_W-3:0]    i_addr_0,
   input  logic                      i_we_0,
   input  mem_bus_pkg::mem_sel_t     i_sel_0,
   input  mem_bus_pkg::mem_word_u    i_wdata_0,
   output logic                      o_ack_0,
   output mem_bus_pkg::mem_word_u    o_rdata_0,
   input  logic                      i_req_1,
   input  logic [`LSU_ADDR_W-3:0]    i_addr_1,
   input  logic                      i_we_1,
   input  mem_bus_pkg::mem_sel_t     i_sel_1,
   input  mem_bus_pkg::mem_word_u    i_wdata_1,
   output logic                      o_ack_1,
   output mem_bus_pkg::mem_word_u    o_rdata_1,
   output logic                      o_en,
   output logic [`LSU_ADDR_W-3:0]    o_addr,
   output logic                      o_we,
   output mem_bus_pkg::mem_sel_t     o_sel,
   output mem_bus_pkg::mem_word_u    o_wdata,
   input  logic                      i_ack,
   input  mem_bus_pkg::mem_word_u    i_rdata
);

   logic busy_q;   // a ram access is in flight.
   logic grant_q;  // granted channel, kept as last served when idle.
   logic en_q;
   logic pick;

   // on a tie the channel not served last wins.
   assign pick = (i_req_0 & i_req_1) ? ~grant_q : i_req_1;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy_q  <= 1'b0;
         grant_q <= 1'b0;
         en_q    <= 1'b0;
      end else begin
         en_q <= 1'b0; // enable lasts one cycle.
         if (!busy_q) begin
            if (i_req_0 | i_req_1) begin
               busy_q  <= 1'b1;
               grant_q <= pick;
               en_q    <= 1'b1;
            end
         end else if (i_ack) begin
            busy_q <= 1'b0;  // grant released, pointer stays.
         end
      end
   end

   assign o_en    = en_q;
   assign o_addr  = grant_q ? i_addr_1  : i_addr_0;
   assign o_we    = grant_q ? i_we_1    : i_we_0;
   assign o_sel   = grant_q ? i_sel_1   : i_sel_0;
   assign o_wdata = grant_q ? i_wdata_1 : i_wdata_0;

   assign o_ack_0   = i_ack & busy_q & ~grant_q;
   assign o_ack_1   = i_ack & busy_q & grant_q;
   assign o_rdata_0 = grant_q ? '0 : i_rdata;
   assign o_rdata_1 = grant_q ? i_rdata : '0;

endmodule

// ==== source/mem_bus_pkg.sv ====
package mem_bus_pkg;

   // number of byte lanes in a ram word.
   localparam int MEM_LANES = 4;

   // byte lane select, bit n enables byte n.
   typedef logic [MEM_LANES-1:0] mem_sel_t;

   // one ram word, seen whole or as byte lanes.
   typedef union packed {
      logic [31:0]                word;  // whole word.
      logic [MEM_LANES-1:0][7:0] bytes; // lane view, bytes[0] is the lsb.
   } mem_word_u;

endpackage

// ==== verification/lsu_subsys_tb.sv ====
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_subsys_tb;
   import lsu_op_pkg::*;

   localparam int AW             = `LSU_ADDR_W;
   localparam int HALF_BYTES     = (1 << AW) / 2;   // each channel owns one address half.
   localparam int WORDS_PER_HALF = HALF_BYTES / 4;
   localparam int TIMEOUT        = 500;             // cycles allowed for any one wait.
   localparam int RANDOM_CMDS    = 150;
   localparam logic [LSU_DATA_W-1:0] SIGN_PAT = 32'h80fe_7f01; // lanes of both signs.

   logic                  i_clk;
   logic                  i_rst_n;
   logic                  i_cmd_strobe_0, i_cmd_strobe_1;
   logic [AW-1:0]         i_addr_0, i_addr_1;
   mem_size_e             i_size_0, i_size_1;
   logic                  i_signed_0, i_signed_1;
   logic                  i_store_0, i_store_1;
   logic [LSU_DATA_W-1:0] i_wdata_0, i_wdata_1;
   logic                  o_done_0, o_done_1;
   logic [LSU_DATA_W-1:0] o_rdata_0, o_rdata_1;
   logic                  o_misalign_0, o_misalign_1;
   logic                  o_busy_0, o_busy_1;

   logic [7:0] model_mem [1 << AW]; // byte mirror of the ram.

   lsu_subsys i_lsu_subsys (.*);

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk; // 8 ns period.
   end

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_word(input string name, input logic [LSU_DATA_W-1:0] exp,
                             input logic [LSU_DATA_W-1:0] act);
      if (act !== exp) begin
         $display("error: %s expected %h actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("error: %s expected %b actual %b", name, exp, act);
         abort_run();
      end
   endtask

   function automatic int size_bytes(input mem_size_e size);
      case (size)
         MEM_BYTE: return 1;
         MEM_HALF: return 2;
         default:  return 4;
      endcase
   endfunction

   // odd half, or word off a 4-byte boundary.
   function automatic logic is_misaligned(input logic [AW-1:0] addr, input mem_size_e size);
      return (size == MEM_HALF && addr[0]) || (size == MEM_WORD && addr[1:0] != 2'b00);
   endfunction

   function automatic logic [LSU_DATA_W-1:0] load_expect(input logic [AW-1:0] addr,
                                                         input mem_size_e size,
                                                         input logic sgn);
      logic [LSU_DATA_W-1:0] val;
      logic [AW-1:0]         idx;
      int                    n;
      n   = size_bytes(size);
      val = '0;
      for (int i = 0; i < n; i++) begin
         idx           = addr + AW'(i);
         val[8*i +: 8] = model_mem[idx]; // little endian assembly.
      end
      if (sgn && val[8*n-1]) val = val | ({LSU_DATA_W{1'b1}} << (8 * n)); // sign fill.
      return val;
   endfunction

   function automatic void store_bytes(input logic [AW-1:0] addr, input mem_size_e size,
                                       input logic [LSU_DATA_W-1:0] data);
      logic [AW-1:0] idx;
      for (int i = 0; i < size_bytes(size); i++) begin
         idx            = addr + AW'(i);
         model_mem[idx] = data[8*i +: 8]; // low bytes of the data.
      end
   endfunction

   function automatic logic busy_level(input int ch);
      return (ch == 0) ? o_busy_0 : o_busy_1;
   endfunction

   function automatic logic done_seen(input int ch);
      return (ch == 0) ? o_done_0 : o_done_1;
   endfunction

   function automatic logic [AW-1:0] rand_word(input logic [AW-1:0] base);
      return base + AW'(4 * $urandom_range(0, WORDS_PER_HALF - 1));
   endfunction

   task automatic drive_cmd(input int ch, input logic stb, input logic [AW-1:0] addr,
                            input mem_size_e size, input logic sgn, input logic st,
                            input logic [LSU_DATA_W-1:0] wdata);
      if (ch == 0) begin
         i_cmd_strobe_0 <= stb;
         i_addr_0       <= addr;
         i_size_0       <= size;
         i_signed_0     <= sgn;
         i_store_0      <= st;
         i_wdata_0      <= wdata;
      end else begin
         i_cmd_strobe_1 <= stb;
         i_addr_1       <= addr;
         i_size_1       <= size;
         i_signed_1     <= sgn;
         i_store_1      <= st;
         i_wdata_1      <= wdata;
      end
   endtask

   task automatic await_idle(input int ch, input string name);
      int cnt;
      cnt = 0;
      @(posedge i_clk);
      while (busy_level(ch) && cnt < TIMEOUT) begin
         @(posedge i_clk);
         cnt++;
      end
      if (busy_level(ch)) begin
         $display("channel %0d stayed busy too long before %s", ch, name);
         abort_run();
      end
   endtask

   task automatic wait_done(input int ch, input string name);
      int cnt;
      cnt = 0;
      @(posedge i_clk);
      while (!done_seen(ch) && cnt < TIMEOUT) begin
         @(posedge i_clk);
         cnt++;
      end
      if (!done_seen(ch)) begin
         $display("channel %0d never signalled done for %s", ch, name);
         abort_run();
      end
   endtask

   // one command, start to done, checked against the byte model.
   task automatic issue_cmd(input int ch, input string name, input logic [AW-1:0] addr,
                            input mem_size_e size, input logic sgn, input logic st,
                            input logic [LSU_DATA_W-1:0] wdata);
      string full;
      logic  mis;
      full = $sformatf("ch%0d %s at %h%s", ch, name, addr, sgn ? " signed" : "");
      mis  = is_misaligned(addr, size);
      await_idle(ch, full);
      drive_cmd(ch, 1'b1, addr, size, sgn, st, wdata);
      @(posedge i_clk);
      drive_cmd(ch, 1'b0, addr, size, sgn, st, wdata); // strobe lasts one cycle.
      wait_done(ch, full);
      check_flag({full, " misalign"}, mis, (ch == 0) ? o_misalign_0 : o_misalign_1);
      if (!mis && st) begin
         store_bytes(addr, size, wdata);          // a trap leaves memory alone.
      end else if (!mis) begin
         check_word(full, load_expect(addr, size, sgn), (ch == 0) ? o_rdata_0 : o_rdata_1);
      end
   endtask

   task automatic run_channel(input int ch);
      logic [AW-1:0]         base;
      logic [AW-1:0]         waddr;
      logic [LSU_DATA_W-1:0] pat;
      base = (ch == 0) ? '0 : AW'(HALF_BYTES);
      // fill the whole half, then read every word back.
      for (int w = 0; w < WORDS_PER_HALF; w++) begin
         issue_cmd(ch, "word store", base + AW'(4 * w), MEM_WORD, 1'b0, 1'b1, $urandom());
      end
      for (int w = 0; w < WORDS_PER_HALF; w++) begin
         issue_cmd(ch, "word load", base + AW'(4 * w), MEM_WORD, 1'b0, 1'b0, '0);
      end
      // narrow stores at each lane, whole word read back.
      for (int off = 0; off < 4; off++) begin
         waddr = rand_word(base);
         issue_cmd(ch, "byte store", waddr + AW'(off), MEM_BYTE, 1'b0, 1'b1, $urandom());
         issue_cmd(ch, "word after byte", waddr, MEM_WORD, 1'b0, 1'b0, '0);
         if (off % 2 == 0) begin
            issue_cmd(ch, "half store", waddr + AW'(off), MEM_HALF, 1'b0, 1'b1, $urandom());
            issue_cmd(ch, "word after half", waddr, MEM_WORD, 1'b0, 1'b0, '0);
         end
      end
      // pattern and its inverse put both signs in every lane.
      pat = SIGN_PAT;
      for (int p = 0; p < 2; p++) begin
         waddr = rand_word(base);
         issue_cmd(ch, "pattern store", waddr, MEM_WORD, 1'b0, 1'b1, pat);
         for (int off = 0; off < 4; off++) begin
            for (int s = 0; s < 2; s++) begin
               issue_cmd(ch, "byte load", waddr + AW'(off), MEM_BYTE, 1'(s), 1'b0, '0);
               if (off % 2 == 0) begin
                  issue_cmd(ch, "half load", waddr + AW'(off), MEM_HALF, 1'(s), 1'b0, '0);
               end
            end
         end
         pat = ~pat;
      end
      // traps, then an aligned load proves the word is unchanged.
      for (int off = 1; off < 4; off++) begin
         waddr = rand_word(base);
         issue_cmd(ch, "bad word store", waddr + AW'(off), MEM_WORD, 1'b0, 1'b1, $urandom());
         issue_cmd(ch, "bad word load", waddr + AW'(off), MEM_WORD, 1'b0, 1'b0, '0);
         if (off % 2 == 1) begin
            issue_cmd(ch, "bad half store", waddr + AW'(off), MEM_HALF, 1'b0, 1'b1, $urandom());
            issue_cmd(ch, "bad half load", waddr + AW'(off), MEM_HALF, 1'b1, 1'b0, '0);
         end
         issue_cmd(ch, "word after trap", waddr, MEM_WORD, 1'b0, 1'b0, '0);
      end
      // mixed traffic, overlapping the other channel.
      for (int n = 0; n < RANDOM_CMDS; n++) begin
         issue_cmd(ch, "random", base + AW'($urandom_range(0, HALF_BYTES - 1)),
                   mem_size_e'(2'($urandom_range(0, 2))), 1'($urandom_range(0, 1)),
                   1'($urandom_range(0, 1)), $urandom());
      end
   endtask

   initial begin
      void'($urandom(47));
      i_rst_n        = 1'b0;
      i_cmd_strobe_0 = 1'b0;
      i_addr_0       = '0;
      i_size_0       = MEM_BYTE;
      i_signed_0     = 1'b0;
      i_store_0      = 1'b0;
      i_wdata_0      = '0;
      i_cmd_strobe_1 = 1'b0;
      i_addr_1       = '0;
      i_size_1       = MEM_BYTE;
      i_signed_1     = 1'b0;
      i_store_1      = 1'b0;
      i_wdata_1      = '0;
      repeat (8) @(posedge i_clk);
      i_rst_n <= 1'b1;
      @(posedge i_clk);
      check_flag("reset busy 0", 1'b0, o_busy_0);
      check_flag("reset busy 1", 1'b0, o_busy_1);
      check_flag("reset done 0", 1'b0, o_done_0);
      check_flag("reset done 1", 1'b0, o_done_1);
      check_flag("reset misalign 0", 1'b0, o_misalign_0);
      check_flag("reset misalign 1", 1'b0, o_misalign_1);
      fork
         run_channel(0);
         run_channel(1);
      join
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule
